/* verif/usart_vectors.txt */
# op then hex arguments, one operation per line
# config ucsrc ubrr | send byte | recv byte fe upe | burst b0 b1 b2 | glitch ticks | irq byte
config 06 003
send a5
recv 5a 0 0
config 26 001
send 3c
recv c3 0 0
recv 81 0 1
recv 7e 1 0
glitch 5
config 3e 002
send f1
recv 96 0 0
config 28 000
send 1b
recv ff 0 0
recv 0d 0 1
config 30 003
send 0e
burst 11 22 33
config 0c 100
send 7f
recv 55 0 0
config 26 001
irq 69

/* sources.f */
src/usart_pkg.sv
src/usart_regs.sv
src/usart_baud_gen.sv
src/usart_fifo.sv
src/usart_rx.sv
src/usart_tx.sv
src/usart_top.sv
verif/usart_properties.sv
verif/usart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the USART testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module usart_tb -f sources.f -o usart_sim

./obj_dir/usart_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verif/usart_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_tb import usart_pkg::*; ();

	localparam int MAX_OPS = 64;

	logic        cp2, ireset;
	logic [11:0] ram_addr_i;
	logic        ramre_i, ramwe_i;
	logic [7:0]  dbus_i, dbus_o;
	logic        out_en_o, rxd_i, txd_o, rxen_o, txen_o;
	logic        rxc_irq_o, txc_irq_o, udre_irq_o;
	logic        irqack_i;
	logic [5:0]  irqack_addr_i;

	logic [63:0] op_name [MAX_OPS];
	logic [11:0] op_a0 [MAX_OPS];
	logic [11:0] op_a1 [MAX_OPS];
	logic [11:0] op_a2 [MAX_OPS];
	int          n_ops, errors, ops_done, bit_cyc;
	logic [7:0]  ucsrc_cur;
	logic [11:0] ubrr_cur;
	longint      limit_ns;
	logic        loaded;

	usart_top dut0 (
		.cp2           (cp2),
		.ireset        (ireset),
		.ram_addr_i    (ram_addr_i),
		.ramre_i       (ramre_i),
		.ramwe_i       (ramwe_i),
		.dbus_i        (dbus_i),
		.dbus_o        (dbus_o),
		.out_en_o      (out_en_o),
		.rxd_i         (rxd_i),
		.txd_o         (txd_o),
		.rxen_o        (rxen_o),
		.txen_o        (txen_o),
		.rxc_irq_o     (rxc_irq_o),
		.txc_irq_o     (txc_irq_o),
		.udre_irq_o    (udre_irq_o),
		.irqack_i      (irqack_i),
		.irqack_addr_i (irqack_addr_i)
	);

	always #5 cp2 = ~cp2;

	function automatic int arg_count(input logic [63:0] name);
		if (name == "config")
			return 2;
		if (name == "recv" || name == "burst")
			return 3;
		if (name == "send" || name == "glitch" || name == "irq")
			return 1;
		return -1;
	endfunction

	function automatic int frame_count(input logic [63:0] name);
		if (name == "burst" || name == "irq")
			return 3;
		if (name == "config")
			return 0;
		return 1;
	endfunction

	function automatic logic [7:0] char_mask(input logic [7:0] c);
		int nb;
		nb = 5 + int'(c[2:1]); // 5 to 8 data bits
		return 8'((1 << nb) - 1);
	endfunction

	task automatic report_mismatch(input string what, input int got, input int exp);
		errors++;
		$display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	task automatic load_vectors(output logic ok);
		logic [63:0]    word;
		logic [8*120-1:0] rest;
		logic [11:0]    a0, a1, a2;
		int             fd, code, na, frames, umax;
		frames = 0;
		umax   = 0;
		n_ops  = 0;
		fd = $fopen("verif/usart_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				word = '0;
				code = $fscanf(fd, "%s", word);
				if (code == 1) begin
					if (word == "#") begin
						code = $fgets(rest, fd); // comment line
					end else begin
						na = arg_count(word);
						a0 = '0;
						a1 = '0;
						a2 = '0;
						if (na > 0)
							code = $fscanf(fd, "%h", a0);
						if (na > 1)
							code = $fscanf(fd, "%h", a1);
						if (na > 2)
							code = $fscanf(fd, "%h", a2);
						if (na < 0 || n_ops >= MAX_OPS) begin
							errors++;
							$display("vector file holds an unknown or extra operation");
							code = $fgets(rest, fd);
						end else begin
							op_name[n_ops] = word;
							op_a0[n_ops]   = a0;
							op_a1[n_ops]   = a1;
							op_a2[n_ops]   = a2;
							n_ops++;
							frames += frame_count(word);
							if (word == "config" && int'(a1) > umax)
								umax = int'(a1);
						end
					end
				end
			end
			$fclose(fd);
		end
		// 13 bit times per frame at the slowest baud rate, plus a margin
		limit_ns = longint'(frames) * 13 * TICKS_PER_BIT * (umax + 1) * 10 + 100000;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [7:0] data);
		@(negedge cp2);
		ram_addr_i = addr;
		dbus_i     = data;
		ramwe_i    = 1'b1;
		@(negedge cp2);
		ramwe_i = 1'b0;
		dbus_i  = 8'h00;
	endtask

	// read held over one rising edge, sampled in the low phase
	task automatic read_reg(input logic [11:0] addr, output logic [7:0] data);
		@(negedge cp2);
		ram_addr_i = addr;
		ramre_i    = 1'b1;
		#2;
		data = dbus_o;
		if (out_en_o !== 1'b1)
			report_mismatch($sformatf("out_en_o on read of %0h", addr), out_en_o, 1);
		@(negedge cp2);
		ramre_i = 1'b0;
	endtask

	task automatic wait_flag(input int pos, input logic val, input string name);
		logic [7:0] s;
		int         n, max_reads;
		n         = 0;
		max_reads = 3 * bit_cyc / 2;
		read_reg(UCSRA_ADDR, s);
		while (s[pos] !== val && n < max_reads) begin
			read_reg(UCSRA_ADDR, s);
			n++;
		end
		if (s[pos] !== val) begin
			errors++;
			$display("%0t: %s did not become %0d within %0d status reads", $time, name, val,
				max_reads);
		end
	endtask

	task automatic send_ack(input logic [5:0] vec);
		@(negedge cp2);
		irqack_i      = 1'b1;
		irqack_addr_i = vec;
		@(negedge cp2);
		irqack_i      = 1'b0;
		irqack_addr_i = 6'h00;
	endtask

	task automatic configure(input logic [7:0] c, input logic [11:0] u);
		logic [7:0] v;
		write_reg(UCSRC_ADDR, c);
		write_reg(UBRRH_ADDR, {4'h0, u[11:8]});
		write_reg(UBRRL_ADDR, u[7:0]);
		write_reg(UCSRB_ADDR, 8'h18); // rxen and txen
		ucsrc_cur = c;
		ubrr_cur  = u;
		bit_cyc   = TICKS_PER_BIT * (int'(u) + 1);
		read_reg(UBRRH_ADDR, v);
		if (v !== {4'h0, u[11:8]})
			report_mismatch("UBRRH", v, {4'h0, u[11:8]});
		read_reg(UBRRL_ADDR, v);
		if (v !== u[7:0])
			report_mismatch("UBRRL", v, u[7:0]);
		read_reg(UCSRC_ADDR, v);
		if (v !== (c & 8'h3E))
			report_mismatch("UCSRC", v, c & 8'h3E);
		if (rxen_o !== 1'b1 || txen_o !== 1'b1)
			report_mismatch("rxen_o and txen_o", {rxen_o, txen_o}, 3);
	endtask

	task automatic transmit_and_check(input logic [7:0] b);
		logic [7:0] d;
		int         i, n, nb;
		nb = 5 + int'(ucsrc_cur[2:1]);
		d  = b & char_mask(ucsrc_cur);
		write_reg(UDR_ADDR, b);
		n = 0;
		while (txd_o !== 1'b0 && n < 4 * bit_cyc) begin
			@(negedge cp2);
			n++;
		end
		if (txd_o !== 1'b0) begin
			errors++;
			$display("%0t: no start bit on txd_o after the UDR write", $time);
		end else begin
			repeat (bit_cyc / 2) @(negedge cp2); // middle of the start bit
			if (txd_o !== 1'b0)
				report_mismatch("txd start bit", txd_o, 0);
			for (i = 0; i < nb; i++) begin
				repeat (bit_cyc) @(negedge cp2);
				if (txd_o !== d[i])
					report_mismatch($sformatf("txd data bit %0d", i), txd_o, d[i]);
			end
			if (ucsrc_cur[UPM1_BIT]) begin
				repeat (bit_cyc) @(negedge cp2);
				if (txd_o !== (^d ^ ucsrc_cur[UPM0_BIT]))
					report_mismatch("txd parity bit", txd_o, ^d ^ ucsrc_cur[UPM0_BIT]);
			end
			for (i = 0; i < (ucsrc_cur[USBS_BIT] ? 2 : 1); i++) begin
				repeat (bit_cyc) @(negedge cp2);
				if (txd_o !== 1'b1)
					report_mismatch($sformatf("txd stop bit %0d", i), txd_o, 1);
			end
			wait_flag(TXC_BIT, 1'b1, "TXC");
		end
	endtask

	task automatic drive_rx_bit(input logic v);
		rxd_i = v;
		repeat (bit_cyc) @(negedge cp2);
	endtask

	task automatic drive_rx_frame(input logic [7:0] b, input logic bad_par,
		input logic bad_stop);
		logic [7:0] d;
		int         i, nb;
		nb = 5 + int'(ucsrc_cur[2:1]);
		d  = b & char_mask(ucsrc_cur);
		@(negedge cp2);
		drive_rx_bit(1'b0);
		for (i = 0; i < nb; i++)
			drive_rx_bit(d[i]);
		if (ucsrc_cur[UPM1_BIT])
			drive_rx_bit(^d ^ ucsrc_cur[UPM0_BIT] ^ bad_par);
		drive_rx_bit(!bad_stop);
		if (ucsrc_cur[USBS_BIT])
			drive_rx_bit(1'b1);
		drive_rx_bit(1'b1); // idle gap
		drive_rx_bit(1'b1);
	endtask

	task automatic receive_and_check(input logic [7:0] b, input logic fe, input logic pe);
		logic [7:0] s, v;
		drive_rx_frame(b, pe, fe);
		wait_flag(RXC_BIT, 1'b1, "RXC");
		read_reg(UCSRA_ADDR, s);
		if (s[FE_BIT] !== fe)
			report_mismatch("FE", s[FE_BIT], fe);
		if (s[UPE_BIT] !== pe)
			report_mismatch("UPE", s[UPE_BIT], pe);
		read_reg(UDR_ADDR, v);
		if (v !== (b & char_mask(ucsrc_cur)))
			report_mismatch("UDR", v, b & char_mask(ucsrc_cur));
		read_reg(UCSRA_ADDR, s);
		if (s[RXC_BIT] !== 1'b0)
			report_mismatch("RXC after the UDR read", s[RXC_BIT], 0);
	endtask

	task automatic run_glitch(input int ticks);
		logic [7:0] s;
		@(negedge cp2);
		rxd_i = 1'b0;
		repeat (ticks * (int'(ubrr_cur) + 1)) @(negedge cp2);
		rxd_i = 1'b1;
		repeat (2 * bit_cyc) @(negedge cp2);
		read_reg(UCSRA_ADDR, s);
		if (s[RXC_BIT] !== 1'b0)
			report_mismatch("RXC after a short start pulse", s[RXC_BIT], 0);
	endtask

	task automatic run_burst(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
		logic [7:0] s, v, m;
		m = char_mask(ucsrc_cur);
		drive_rx_frame(b0, 1'b0, 1'b0);
		drive_rx_frame(b1, 1'b0, 1'b0);
		drive_rx_frame(b2, 1'b0, 1'b0); // buffer full, this one is lost
		wait_flag(DOR_BIT, 1'b1, "DOR");
		read_reg(UDR_ADDR, v);
		if (v !== (b0 & m))
			report_mismatch("UDR first burst byte", v, b0 & m);
		read_reg(UDR_ADDR, v);
		if (v !== (b1 & m))
			report_mismatch("UDR second burst byte", v, b1 & m);
		read_reg(UCSRA_ADDR, s);
		if (s[DOR_BIT] !== 1'b0 || s[RXC_BIT] !== 1'b0)
			report_mismatch("DOR and RXC after the reads", {s[DOR_BIT], s[RXC_BIT]}, 0);
	endtask

	task automatic run_irq(input logic [7:0] b);
		logic [7:0] v;
		write_reg(UCSRB_ADDR, 8'hF8); // all three enables
		if ({rxc_irq_o, txc_irq_o, udre_irq_o} !== 3'b001)
			report_mismatch("irq lines with empty buffers", {rxc_irq_o, txc_irq_o, udre_irq_o}, 1);
		transmit_and_check(b);
		if (txc_irq_o !== 1'b1)
			report_mismatch("txc_irq_o after a frame", txc_irq_o, 1);
		send_ack(6'h13);
		if (txc_irq_o !== 1'b1)
			report_mismatch("txc_irq_o after ack at another vector", txc_irq_o, 1);
		send_ack(TXC_VECTOR);
		if (txc_irq_o !== 1'b0)
			report_mismatch("txc_irq_o after the TXC ack", txc_irq_o, 0);
		read_reg(UCSRA_ADDR, v);
		if (v[TXC_BIT] !== 1'b0)
			report_mismatch("TXC after the ack", v[TXC_BIT], 0);
		transmit_and_check(~b);
		if (txc_irq_o !== 1'b1)
			report_mismatch("txc_irq_o after the second frame", txc_irq_o, 1);
		write_reg(UCSRA_ADDR, 8'h40);
		if (txc_irq_o !== 1'b0)
			report_mismatch("txc_irq_o after writing one to TXC", txc_irq_o, 0);
		drive_rx_frame(b, 1'b0, 1'b0);
		wait_flag(RXC_BIT, 1'b1, "RXC");
		if (rxc_irq_o !== 1'b1)
			report_mismatch("rxc_irq_o with a byte waiting", rxc_irq_o, 1);
		read_reg(UDR_ADDR, v);
		if (v !== (b & char_mask(ucsrc_cur)))
			report_mismatch("UDR in the irq test", v, b & char_mask(ucsrc_cur));
		if (rxc_irq_o !== 1'b0)
			report_mismatch("rxc_irq_o after the UDR read", rxc_irq_o, 0);
		write_reg(UCSRB_ADDR, 8'h18);
		if (udre_irq_o !== 1'b0)
			report_mismatch("udre_irq_o with UDRIE off", udre_irq_o, 0);
	endtask

	task automatic check_reset_values();
		logic [7:0] v;
		if (txd_o !== 1'b1 || rxen_o !== 1'b0 || txen_o !== 1'b0)
			report_mismatch("txd_o, rxen_o, txen_o after reset", {txd_o, rxen_o, txen_o}, 4);
		if ({rxc_irq_o, txc_irq_o, udre_irq_o} !== 3'b000)
			report_mismatch("irq lines after reset", {rxc_irq_o, txc_irq_o, udre_irq_o}, 0);
		if (out_en_o !== 1'b0)
			report_mismatch("out_en_o with no read", out_en_o, 0);
		read_reg(UCSRA_ADDR, v);
		if (v !== 8'h20)
			report_mismatch("UCSRA after reset", v, 8'h20);
		read_reg(UCSRB_ADDR, v);
		if (v !== 8'h00)
			report_mismatch("UCSRB after reset", v, 0);
		read_reg(UCSRC_ADDR, v);
		if (v !== 8'h06)
			report_mismatch("UCSRC after reset", v, 8'h06);
		read_reg(UBRRH_ADDR, v);
		if (v !== 8'h00)
			report_mismatch("UBRRH after reset", v, 0);
		read_reg(UBRRL_ADDR, v);
		if (v !== 8'h00)
			report_mismatch("UBRRL after reset", v, 0);
		@(negedge cp2);
		ram_addr_i = 12'h0C3; // not a USART address
		ramre_i    = 1'b1;
		#2;
		if (out_en_o !== 1'b0 || dbus_o !== 8'h00)
			report_mismatch("out_en_o and dbus_o on a miss", {out_en_o, dbus_o}, 0);
		@(negedge cp2);
		ramre_i = 1'b0;
	endtask

	initial begin
		wait (loaded);
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display("Errors found");
		$finish;
	end

	initial begin
		logic ok;
		logic [7:0] v;
		int k;
		cp2           = 1'b0;
		ireset        = 1'b0;
		ram_addr_i    = 12'h000;
		ramre_i       = 1'b0;
		ramwe_i       = 1'b0;
		dbus_i        = 8'h00;
		rxd_i         = 1'b1;
		irqack_i      = 1'b0;
		irqack_addr_i = 6'h00;
		errors        = 0;
		ops_done      = 0;
		loaded        = 1'b0;
		ucsrc_cur     = 8'h06;
		ubrr_cur      = 12'h000;
		bit_cyc       = TICKS_PER_BIT;
		load_vectors(ok);
		if (!ok) begin
			$display("could not open the vector file verif/usart_vectors.txt");
			$display("Errors found");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (2) @(negedge cp2);
			ireset = 1'b1;
			check_reset_values();
			for (k = 0; k < n_ops; k++) begin
				if (op_name[k] == "config") begin
					configure(op_a0[k][7:0], op_a1[k]);
				end else if (op_name[k] == "send") begin
					transmit_and_check(op_a0[k][7:0]);
					write_reg(UCSRA_ADDR, 8'h40); // clear TXC for the next frame
					read_reg(UCSRA_ADDR, v);
					if (v[TXC_BIT] !== 1'b0 || v[UDRE_BIT] !== 1'b1)
						report_mismatch("TXC and UDRE after clear", {v[TXC_BIT], v[UDRE_BIT]}, 1);
				end else if (op_name[k] == "recv") begin
					receive_and_check(op_a0[k][7:0], op_a1[k][0], op_a2[k][0]);
				end else if (op_name[k] == "burst") begin
					run_burst(op_a0[k][7:0], op_a1[k][7:0], op_a2[k][7:0]);
				end else if (op_name[k] == "glitch") begin
					run_glitch(int'(op_a0[k]));
				end else begin
					run_irq(op_a0[k][7:0]);
				end
				ops_done++;
			end
			$display("errors: %0d in the testbench, %0d in assertions, operations run: %0d",
				errors, dut0.props0.fail_count, ops_done);
			if (errors == 0 && dut0.props0.fail_count == 0)
				$display("No errors");
			else
				$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verif/usart_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_properties import usart_pkg::*; (
	input logic       cp2,
	input logic       ireset,
	input logic       ramre_i,
	input logic       out_en_o,
	input logic       txd_o,
	input logic       txen_o,
	input logic       txc_irq_o,
	input logic       irqack_i,
	input logic [5:0] irqack_addr_i
);

	int fail_count = 0; // seen by the testbench at the end

	out_en_needs_re: assert property (@(posedge cp2) disable iff (!ireset)
		out_en_o |-> ramre_i)
		else begin
			fail_count++;
			$error("out_en_o high without ramre_i");
		end

	// line idles high while the transmitter is off
	txd_idle_when_off: assert property (@(posedge cp2) disable iff (!ireset)
		!txen_o |-> txd_o)
		else begin
			fail_count++;
			$error("txd_o low while txen_o is 0");
		end

	txc_ack_clears: assert property (@(posedge cp2) disable iff (!ireset)
		(irqack_i && irqack_addr_i == TXC_VECTOR) |=> !txc_irq_o)
		else begin
			fail_count++;
			$error("txc_irq_o still high after the TXC acknowledge");
		end

endmodule

bind usart_top usart_properties props0 (
	.cp2           (cp2),
	.ireset        (ireset),
	.ramre_i       (ramre_i),
	.out_en_o      (out_en_o),
	.txd_o         (txd_o),
	.txen_o        (txen_o),
	.txc_irq_o     (txc_irq_o),
	.irqack_i      (irqack_i),
	.irqack_addr_i (irqack_addr_i)
);

`default_nettype wire

/* src/usart_top.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_top import usart_pkg::*; #(
	parameter logic [11:0] UDR_A    = UDR_ADDR,
	parameter logic [11:0] UCSRA_A  = UCSRA_ADDR,
	parameter logic [11:0] UCSRB_A  = UCSRB_ADDR,
	parameter logic [11:0] UCSRC_A  = UCSRC_ADDR,
	parameter logic [11:0] UBRRH_A  = UBRRH_ADDR,
	parameter logic [11:0] UBRRL_A  = UBRRL_ADDR,
	parameter logic [5:0]  TXC_VEC  = TXC_VECTOR,
	parameter int          RX_DEPTH = 2,
	parameter int          TX_DEPTH = 1
) (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] ram_addr_i,
	input  logic        ramre_i,
	input  logic        ramwe_i,
	input  logic [7:0]  dbus_i,
	output logic [7:0]  dbus_o,
	output logic        out_en_o,
	input  logic        rxd_i,
	output logic        txd_o,
	output logic        rxen_o,
	output logic        txen_o,
	output logic        rxc_irq_o,
	output logic        txc_irq_o,
	output logic        udre_irq_o,
	input  logic        irqack_i,
	input  logic [5:0]  irqack_addr_i
);

	logic                 rx_en, tx_en, two_stop;
	logic [1:0]           char_size, parity_mode;
	logic [11:0]          ubrr;
	logic                 baud_restart, baud_tick;
	logic                 udr_rd, udr_wr, rx_flush;
	logic                 rx_push, rx_full, rx_empty;
	logic [RX_WORD_W-1:0] rx_word, rx_head;
	logic                 tx_pop, tx_full, tx_empty, tx_frame_done;
	logic [TX_WORD_W-1:0] tx_head;

	usart_regs #(
		.UDR_A   (UDR_A),
		.UCSRA_A (UCSRA_A),
		.UCSRB_A (UCSRB_A),
		.UCSRC_A (UCSRC_A),
		.UBRRH_A (UBRRH_A),
		.UBRRL_A (UBRRL_A),
		.TXC_VEC (TXC_VEC)
	) regs0 (
		.cp2             (cp2),
		.ireset          (ireset),
		.ram_addr_i      (ram_addr_i),
		.ramre_i         (ramre_i),
		.ramwe_i         (ramwe_i),
		.dbus_i          (dbus_i),
		.dbus_o          (dbus_o),
		.out_en_o        (out_en_o),
		.irqack_i        (irqack_i),
		.irqack_addr_i   (irqack_addr_i),
		.rx_en_o         (rx_en),
		.tx_en_o         (tx_en),
		.char_size_o     (char_size),
		.parity_mode_o   (parity_mode),
		.two_stop_o      (two_stop),
		.ubrr_o          (ubrr),
		.baud_restart_o  (baud_restart),
		.udr_rd_o        (udr_rd),
		.udr_wr_o        (udr_wr),
		.rx_flush_o      (rx_flush),
		.rx_head_i       (rx_head),
		.rx_push_i       (rx_push),
		.rx_full_i       (rx_full),
		.rx_empty_i      (rx_empty),
		.tx_full_i       (tx_full),
		.tx_empty_i      (tx_empty),
		.tx_frame_done_i (tx_frame_done),
		.rxc_irq_o       (rxc_irq_o),
		.txc_irq_o       (txc_irq_o),
		.udre_irq_o      (udre_irq_o)
	);

	usart_baud_gen baud0 (
		.cp2         (cp2),
		.ireset      (ireset),
		.ubrr_i      (ubrr),
		.restart_i   (baud_restart),
		.baud_tick_o (baud_tick)
	);

	usart_fifo #(.WIDTH(RX_WORD_W), .DEPTH(RX_DEPTH)) rx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.din_i   (rx_word),
		.push_i  (rx_push),
		.pop_i   (udr_rd),
		.flush_i (rx_flush),
		.dout_o  (rx_head),
		.full_o  (rx_full),
		.empty_o (rx_empty)
	);

	usart_fifo #(.WIDTH(TX_WORD_W), .DEPTH(TX_DEPTH)) tx_fifo (
		.cp2     (cp2),
		.ireset  (ireset),
		.din_i   (dbus_i),
		.push_i  (udr_wr),
		.pop_i   (tx_pop),
		.flush_i (1'b0), // tx buffer drains on its own
		.dout_o  (tx_head),
		.full_o  (tx_full),
		.empty_o (tx_empty)
	);

	usart_rx rx0 (
		.cp2           (cp2),
		.ireset        (ireset),
		.rxd_i         (rxd_i),
		.rx_en_i       (rx_en),
		.baud_tick_i   (baud_tick),
		.char_size_i   (char_size),
		.parity_mode_i (parity_mode),
		.rx_push_o     (rx_push),
		.rx_word_o     (rx_word)
	);

	usart_tx tx0 (
		.cp2             (cp2),
		.ireset          (ireset),
		.tx_en_i         (tx_en),
		.baud_tick_i     (baud_tick),
		.char_size_i     (char_size),
		.parity_mode_i   (parity_mode),
		.two_stop_i      (two_stop),
		.tx_data_i       (tx_head),
		.tx_empty_i      (tx_empty),
		.tx_pop_o        (tx_pop),
		.tx_frame_done_o (tx_frame_done),
		.txd_o           (txd_o)
	);

	assign rxen_o = rx_en;
	assign txen_o = tx_en;

endmodule

`default_nettype wire

/* src/usart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_tx import usart_pkg::*; (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic                 tx_en_i,
	input  logic                 baud_tick_i,
	input  logic [1:0]           char_size_i,
	input  logic [1:0]           parity_mode_i,
	input  logic                 two_stop_i,
	input  logic [TX_WORD_W-1:0] tx_data_i,
	input  logic                 tx_empty_i,
	output logic                 tx_pop_o,
	output logic                 tx_frame_done_o,
	output logic                 txd_o
);

	tx_state_t   state_q;
	logic [11:0] sh_q;
	logic [11:0] frame;
	logic [3:0]  tick_q;
	logic [3:0]  bits_q; // bits left in the frame
	logic [3:0]  nbits, frame_len;
	logic [7:0]  mask, data_m;
	logic        par_en, par_bit, bit_end;

	assign nbits     = 4'd5 + {2'b00, char_size_i};
	assign par_en    = parity_mode_i[1];
	assign mask      = 8'hFF >> (2'd3 - char_size_i);
	assign data_m    = tx_data_i & mask;
	assign par_bit   = ^data_m ^ parity_mode_i[0];
	assign frame_len = nbits + 4'd2 + {3'b000, par_en} + {3'b000, two_stop_i};

	// start, data, parity, then ones for the stop bits
	always_comb begin
		frame      = 12'hFFF;
		frame[0]   = 1'b0;
		frame[8:1] = data_m | ~mask;
		if (par_en)
			frame[nbits + 4'd1] = par_bit;
	end

	assign tx_pop_o = (state_q == TX_IDLE) && tx_en_i && !tx_empty_i;
	assign bit_end  = baud_tick_i && (tick_q == 4'(TICKS_PER_BIT - 1));
	assign txd_o    = (state_q == TX_SHIFT && tx_en_i) ? sh_q[0] : 1'b1;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state_q         <= TX_IDLE;
			tick_q          <= 4'd0;
			bits_q          <= 4'd0;
			tx_frame_done_o <= 1'b0;
		end else begin
			tx_frame_done_o <= 1'b0;
			case (state_q)
				TX_IDLE: begin
					if (tx_pop_o) begin
						state_q <= TX_SHIFT;
						tick_q  <= 4'd0;
						bits_q  <= frame_len;
					end
				end
				TX_SHIFT: begin
					if (!tx_en_i) begin
						state_q <= TX_IDLE; // abort on disable
					end else if (baud_tick_i) begin
						tick_q <= bit_end ? 4'd0 : tick_q + 4'd1;
						if (bit_end) begin
							bits_q <= bits_q - 4'd1;
							if (bits_q == 4'd1) begin
								state_q         <= TX_IDLE;
								tx_frame_done_o <= 1'b1;
							end
						end
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge cp2) begin
		if (tx_pop_o)
			sh_q <= frame;
		else if (state_q == TX_SHIFT && bit_end)
			sh_q <= {1'b1, sh_q[11:1]};
	end

endmodule

`default_nettype wire

/* src/usart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_rx import usart_pkg::*; (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic                 rxd_i,
	input  logic                 rx_en_i,
	input  logic                 baud_tick_i,
	input  logic [1:0]           char_size_i,
	input  logic [1:0]           parity_mode_i,
	output logic                 rx_push_o,
	output logic [RX_WORD_W-1:0] rx_word_o
);

	rx_state_t  state_q;
	logic [1:0] sync_q;
	logic       rxd_s, rxd_d_q;
	logic       fall_q;
	logic [3:0] tick_q; // index of the next tick within the bit
	logic [1:0] samp_q;
	logic       maj, last_sample;
	logic [3:0] bits_q; // data, parity and stop bits still to come
	logic [8:0] sh_q;
	logic [3:0] nbits, shamt;
	logic       par_en, par_err;
	logic [8:0] aligned;
	logic [7:0] mask, data;

	assign rxd_s = sync_q[1];

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			sync_q  <= 2'b11; // line idles high
			rxd_d_q <= 1'b1;
		end else begin
			sync_q  <= {sync_q[0], rxd_i};
			rxd_d_q <= rxd_s;
		end
	end

	// two stored samples plus the live one at the third tick
	assign maj = (samp_q[0] & samp_q[1]) | (samp_q[0] & rxd_s) | (samp_q[1] & rxd_s);
	assign last_sample = baud_tick_i && (tick_q == 4'(SAMPLE_FIRST + 2));

	// received bits sit at the top of sh_q, lsb first
	assign nbits   = 4'd5 + {2'b00, char_size_i};
	assign par_en  = parity_mode_i[1];
	assign shamt   = 4'd9 - nbits - {3'b000, par_en};
	assign aligned = sh_q >> shamt;
	assign mask    = 8'hFF >> (2'd3 - char_size_i);
	assign data    = aligned[7:0] & mask;
	assign par_err = par_en && (sh_q[8] != (^data ^ parity_mode_i[0])); // upm0 = odd

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state_q   <= RX_IDLE;
			fall_q    <= 1'b0;
			tick_q    <= 4'd0;
			samp_q    <= 2'b11;
			bits_q    <= 4'd0;
			rx_push_o <= 1'b0;
		end else begin
			rx_push_o <= 1'b0;
			if (!rx_en_i) begin
				state_q <= RX_IDLE;
				fall_q  <= 1'b0;
			end else if (state_q == RX_IDLE) begin
				if (rxd_d_q && !rxd_s)
					fall_q <= 1'b1;
				if (fall_q && baud_tick_i) begin
					state_q <= RX_START;
					fall_q  <= 1'b0;
					tick_q  <= 4'd1; // this tick is tick 0 of the start bit
				end
			end else begin
				if (baud_tick_i) begin
					tick_q <= (tick_q == 4'(TICKS_PER_BIT - 1)) ? 4'd0 : tick_q + 4'd1;
					if (tick_q == 4'(SAMPLE_FIRST) || tick_q == 4'(SAMPLE_FIRST + 1))
						samp_q <= {samp_q[0], rxd_s};
				end
				if (last_sample) begin
					if (state_q == RX_START) begin
						if (maj) begin
							state_q <= RX_IDLE; // false start
						end else begin
							state_q <= RX_DATA;
							bits_q  <= nbits + {3'b000, par_en} + 4'd1;
						end
					end else if (bits_q == 4'd1) begin
						state_q   <= RX_IDLE; // first stop bit done
						rx_push_o <= 1'b1;
					end else begin
						bits_q <= bits_q - 4'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge cp2) begin
		if (state_q == RX_DATA && last_sample) begin
			if (bits_q == 4'd1)
				rx_word_o <= {!maj, par_err, data}; // fe when stop reads 0
			else
				sh_q <= {maj, sh_q[8:1]};
		end
	end

endmodule

`default_nettype wire

/* src/usart_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 2
) (
	input  logic             cp2,
	input  logic             ireset,
	input  logic [WIDTH-1:0] din_i,
	input  logic             push_i,
	input  logic             pop_i,
	input  logic             flush_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             full_o,
	output logic             empty_o
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wr_ptr_q, rd_ptr_q;
	logic [PW-1:0]    wr_nxt, rd_nxt;
	logic [CW-1:0]    count_q;
	logic             do_push, do_pop;

	assign do_push = push_i && !full_o; // dropped when full
	assign do_pop  = pop_i && !empty_o;
	assign wr_nxt  = (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
	assign rd_nxt  = (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else if (flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_nxt;
			if (do_pop)
				rd_ptr_q <= rd_nxt;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge cp2) begin
		if (do_push && !flush_i)
			mem[wr_ptr_q] <= din_i;
	end

	assign dout_o  = mem[rd_ptr_q]; // show-ahead
	assign full_o  = (count_q == CW'(DEPTH));
	assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* src/usart_baud_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_baud_gen (
	input  logic        cp2,
	input  logic        ireset,
	input  logic [11:0] ubrr_i,
	input  logic        restart_i,
	output logic        baud_tick_o
);

	logic [11:0] cnt_q;

	// counts ubrr down to 0, one tick per reload
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			cnt_q <= 12'h000;
		else if (restart_i || (cnt_q == 12'h000))
			cnt_q <= ubrr_i;
		else
			cnt_q <= cnt_q - 12'd1;
	end

	assign baud_tick_o = (cnt_q == 12'h000) && !restart_i;

endmodule

`default_nettype wire

/* src/usart_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module usart_regs import usart_pkg::*; #(
	parameter logic [11:0] UDR_A   = UDR_ADDR,
	parameter logic [11:0] UCSRA_A = UCSRA_ADDR,
	parameter logic [11:0] UCSRB_A = UCSRB_ADDR,
	parameter logic [11:0] UCSRC_A = UCSRC_ADDR,
	parameter logic [11:0] UBRRH_A = UBRRH_ADDR,
	parameter logic [11:0] UBRRL_A = UBRRL_ADDR,
	parameter logic [5:0]  TXC_VEC = TXC_VECTOR
) (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic [11:0]          ram_addr_i,
	input  logic                 ramre_i,
	input  logic                 ramwe_i,
	input  logic [7:0]           dbus_i,
	output logic [7:0]           dbus_o,
	output logic                 out_en_o,
	input  logic                 irqack_i,
	input  logic [5:0]           irqack_addr_i,
	output logic                 rx_en_o,
	output logic                 tx_en_o,
	output logic [1:0]           char_size_o,
	output logic [1:0]           parity_mode_o,
	output logic                 two_stop_o,
	output logic [11:0]          ubrr_o,
	output logic                 baud_restart_o,
	output logic                 udr_rd_o,
	output logic                 udr_wr_o,
	output logic                 rx_flush_o,
	input  logic [RX_WORD_W-1:0] rx_head_i,
	input  logic                 rx_push_i,
	input  logic                 rx_full_i,
	input  logic                 rx_empty_i,
	input  logic                 tx_full_i,
	input  logic                 tx_empty_i,
	input  logic                 tx_frame_done_i,
	output logic                 rxc_irq_o,
	output logic                 txc_irq_o,
	output logic                 udre_irq_o
);

	// writable bits, the rest read as zero
	localparam logic [7:0] UCSRB_WMASK = 8'((1 << RXCIE_BIT) | (1 << TXCIE_BIT) |
		(1 << UDRIE_BIT) | (1 << RXEN_BIT) | (1 << TXEN_BIT));
	localparam logic [7:0] UCSRC_WMASK = 8'((1 << UPM1_BIT) | (1 << UPM0_BIT) |
		(1 << USBS_BIT) | (1 << UCSZ1_BIT) | (1 << UCSZ0_BIT));

	logic [7:0]  ucsrb_q;
	logic [7:0]  ucsrc_q;
	logic [11:0] ubrr_q;
	logic [3:0]  ubrrh_tmp_q; // high byte waits for the low byte write
	logic        txc_q;
	logic        dor_q;
	logic [7:0]  status;
	logic        wr_ucsra, wr_ucsrb, wr_ucsrc, wr_ubrrh, wr_ubrrl;
	logic        txc_ack;

	assign wr_ucsra = ramwe_i && (ram_addr_i == UCSRA_A);
	assign wr_ucsrb = ramwe_i && (ram_addr_i == UCSRB_A);
	assign wr_ucsrc = ramwe_i && (ram_addr_i == UCSRC_A);
	assign wr_ubrrh = ramwe_i && (ram_addr_i == UBRRH_A);
	assign wr_ubrrl = ramwe_i && (ram_addr_i == UBRRL_A);
	assign txc_ack  = irqack_i && (irqack_addr_i == TXC_VEC);

	assign udr_rd_o       = ramre_i && (ram_addr_i == UDR_A); // pops rx buffer
	assign udr_wr_o       = ramwe_i && (ram_addr_i == UDR_A) && tx_en_o;
	assign rx_flush_o     = wr_ucsrb && ucsrb_q[RXEN_BIT] && !dbus_i[RXEN_BIT];

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ucsrb_q        <= 8'h00;
			ucsrc_q        <= 8'h06; // 8 data bits
			ubrr_q         <= 12'h000;
			ubrrh_tmp_q    <= 4'h0;
			baud_restart_o <= 1'b0;
		end else begin
			baud_restart_o <= wr_ubrrl; // new ubrr is already in place
			if (wr_ucsrb)
				ucsrb_q <= dbus_i & UCSRB_WMASK;
			if (wr_ucsrc)
				ucsrc_q <= dbus_i & UCSRC_WMASK;
			if (wr_ubrrh)
				ubrrh_tmp_q <= dbus_i[3:0];
			if (wr_ubrrl)
				ubrr_q <= {ubrrh_tmp_q, dbus_i}; // commit both bytes
		end
	end

	// txc and dor, set wins over clear
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			txc_q <= 1'b0;
			dor_q <= 1'b0;
		end else begin
			if (tx_frame_done_i && tx_empty_i)
				txc_q <= 1'b1;
			else if (txc_ack || (wr_ucsra && dbus_i[TXC_BIT]))
				txc_q <= 1'b0;
			if (rx_push_i && rx_full_i)
				dor_q <= 1'b1; // frame lost
			else if (udr_rd_o)
				dor_q <= 1'b0;
		end
	end

	always_comb begin
		status = 8'h00;
		status[RXC_BIT]  = !rx_empty_i;
		status[TXC_BIT]  = txc_q;
		status[UDRE_BIT] = !tx_full_i;
		status[FE_BIT]   = !rx_empty_i && rx_head_i[RX_WORD_W-1];
		status[DOR_BIT]  = dor_q;
		status[UPE_BIT]  = !rx_empty_i && rx_head_i[RX_WORD_W-2];
	end

	always_comb begin
		dbus_o   = 8'h00;
		out_en_o = ramre_i;
		case (ram_addr_i)
			UDR_A:   dbus_o = rx_empty_i ? 8'h00 : rx_head_i[7:0];
			UCSRA_A: dbus_o = status;
			UCSRB_A: dbus_o = ucsrb_q;
			UCSRC_A: dbus_o = ucsrc_q;
			UBRRH_A: dbus_o = {4'h0, ubrr_q[11:8]};
			UBRRL_A: dbus_o = ubrr_q[7:0];
			default: out_en_o = 1'b0; // not ours
		endcase
	end

	assign rx_en_o       = ucsrb_q[RXEN_BIT];
	assign tx_en_o       = ucsrb_q[TXEN_BIT];
	assign char_size_o   = {ucsrc_q[UCSZ1_BIT], ucsrc_q[UCSZ0_BIT]};
	assign parity_mode_o = {ucsrc_q[UPM1_BIT], ucsrc_q[UPM0_BIT]};
	assign two_stop_o    = ucsrc_q[USBS_BIT];
	assign ubrr_o        = ubrr_q;

	assign rxc_irq_o  = ucsrb_q[RXCIE_BIT] && status[RXC_BIT];
	assign txc_irq_o  = ucsrb_q[TXCIE_BIT] && status[TXC_BIT];
	assign udre_irq_o = ucsrb_q[UDRIE_BIT] && status[UDRE_BIT];

endmodule

`default_nettype wire

/* src/usart_pkg.sv */
`default_nettype none

package usart_pkg;

	// default bus map
	localparam logic [11:0] UDR_ADDR   = 12'h0C6;
	localparam logic [11:0] UCSRA_ADDR = 12'h0C0;
	localparam logic [11:0] UCSRB_ADDR = 12'h0C1;
	localparam logic [11:0] UCSRC_ADDR = 12'h0C2;
	localparam logic [11:0] UBRRH_ADDR = 12'h0C5;
	localparam logic [11:0] UBRRL_ADDR = 12'h0C4;
	localparam logic [5:0]  TXC_VECTOR = 6'h14; // tx complete ack vector

	// UCSRA
	localparam int RXC_BIT  = 7;
	localparam int TXC_BIT  = 6;
	localparam int UDRE_BIT = 5;
	localparam int FE_BIT   = 4;
	localparam int DOR_BIT  = 3;
	localparam int UPE_BIT  = 2;

	// UCSRB
	localparam int RXCIE_BIT = 7;
	localparam int TXCIE_BIT = 6;
	localparam int UDRIE_BIT = 5;
	localparam int RXEN_BIT  = 4;
	localparam int TXEN_BIT  = 3;

	// UCSRC, async fields only
	localparam int UPM1_BIT  = 5;
	localparam int UPM0_BIT  = 4;
	localparam int USBS_BIT  = 3;
	localparam int UCSZ1_BIT = 2;
	localparam int UCSZ0_BIT = 1;

	localparam int TICKS_PER_BIT = 16;
	localparam int SAMPLE_FIRST  = 7; // samples at 7, 8, 9
	localparam int RX_WORD_W     = 10; // {fe, upe, data}
	localparam int TX_WORD_W     = 8;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA} rx_state_t;
	typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

endpackage

`default_nettype wire
